// File: include/rv32i_defs.svh
`ifndef RV32I_DEFS_SVH
`define RV32I_DEFS_SVH

`define XLEN 32

// Weakly not taken
`define CTR_RESET 2'b01

`endif

// File: design/rv32i_pkg.sv
`include "rv32i_defs.svh"

package rv32i_pkg;

    typedef logic [`XLEN-1:0] rv32i_word;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    typedef enum logic [2:0] {
        alu_add,
        alu_sll,
        alu_sra,
        alu_sub,
        alu_xor,
        alu_srl,
        alu_or,
        alu_and
    } alu_ops;

    typedef enum logic {mux1_rs1, mux1_pc} alumux1_sel_t;

    typedef enum logic [2:0] {
        mux2_i_imm,
        mux2_u_imm,
        mux2_b_imm,
        mux2_s_imm,
        mux2_j_imm,
        mux2_rs2
    } alumux2_sel_t;

    typedef enum logic {cmp_rs2, cmp_i_imm} cmpmux_sel_t;

    // All zero is a bubble
    typedef struct packed {
        rv32i_opcode opcode;
        alu_ops      aluop;
        logic [2:0]  cmpop;
        logic        load_regfile;
        logic [4:0]  rd;
        logic        mem_read;
        logic        mem_write;
        logic [2:0]  funct3;
    } rv32i_control_word;

    localparam rv32i_word NOP_INSTR = 32'h00000013; // addi x0, x0, 0

endpackage

// File: design/bp_if.sv
`timescale 1ns/1ps

interface bp_if #(
    parameter int PRED_IDX_W = 4
);
    import rv32i_pkg::*;

    // Lookup in the same cycle as the fetched instruction
    rv32i_word             pc;
    rv32i_opcode           op;
    rv32i_word             imm;
    logic                  pred;
    rv32i_word             pred_addr;
    logic [PRED_IDX_W-1:0] idx;

    // Update strobe from execute
    logic                  update;
    logic                  taken;
    logic [PRED_IDX_W-1:0] update_idx;

    modport decode (output pc, op, imm, update, taken, update_idx,
                    input  pred, pred_addr, idx);

    modport predictor (input  pc, op, imm, update, taken, update_idx,
                       output pred, pred_addr, idx);

endinterface

// File: design/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load,
    input  rv32i_pkg::rv32i_word in,
    input  logic [4:0]           src_a,
    input  logic [4:0]           src_b,
    input  logic [4:0]           dest,
    output rv32i_pkg::rv32i_word reg_a,
    output rv32i_pkg::rv32i_word reg_b
);
    import rv32i_pkg::*;

    rv32i_word data [32];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 32; i++)
                data[i] <= '0;
        end
        else if (load && (dest != 5'd0))
            data[dest] <= in;
    end

    // Write-through so WB and ID can share a cycle
    always_comb
    begin
        if (src_a == 5'd0)
            reg_a = '0;
        else if (load && (src_a == dest))
            reg_a = in;
        else
            reg_a = data[src_a];

        if (src_b == 5'd0)
            reg_b = '0;
        else if (load && (src_b == dest))
            reg_b = in;
        else
            reg_b = data[src_b];
    end

endmodule

// File: design/control_rom.sv
`timescale 1ns/1ps

module control_rom (
    input  rv32i_pkg::rv32i_word         data,
    output rv32i_pkg::rv32i_control_word ctrl,
    output rv32i_pkg::alumux1_sel_t      alumux1_sel,
    output rv32i_pkg::alumux2_sel_t      alumux2_sel,
    output rv32i_pkg::cmpmux_sel_t       cmpmux_sel
);
    import rv32i_pkg::*;

    rv32i_opcode opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;

    assign opcode = rv32i_opcode'(data[6:0]);
    assign funct3 = data[14:12];
    assign funct7 = data[31:25];

    // Shared by op-imm and op-reg; sub only exists for register form
    function automatic alu_ops arith_op(input logic [2:0] f3, input logic alt,
                                        input logic is_reg);
        alu_ops op;
        case (f3)
            3'b000:  op = (alt && is_reg) ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b100:  op = alu_xor;
            3'b101:  op = alt ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            3'b111:  op = alu_and;
            default: op = alu_add; // slt/sltu go through the comparator
        endcase
        return op;
    endfunction

    always_comb
    begin
        ctrl        = '0;
        alumux1_sel = mux1_rs1;
        alumux2_sel = mux2_i_imm;
        cmpmux_sel  = cmp_rs2;

        case (opcode)
            op_lui:
            begin
                ctrl.load_regfile = 1'b1;
                alumux2_sel       = mux2_u_imm;
            end
            op_auipc:
            begin
                ctrl.load_regfile = 1'b1;
                alumux1_sel       = mux1_pc;
                alumux2_sel       = mux2_u_imm;
            end
            op_jal:
            begin
                ctrl.load_regfile = 1'b1;
                alumux1_sel       = mux1_pc;
                alumux2_sel       = mux2_j_imm;
            end
            op_jalr:  ctrl.load_regfile = 1'b1;      // rs1 + i_imm
            op_br:
            begin
                ctrl.cmpop  = funct3;
                alumux1_sel = mux1_pc;
                alumux2_sel = mux2_b_imm;
            end
            op_load:
            begin
                ctrl.load_regfile = 1'b1;
                ctrl.mem_read     = 1'b1;
            end
            op_store:
            begin
                ctrl.mem_write = 1'b1;
                alumux2_sel    = mux2_s_imm;
            end
            op_imm, op_reg:
            begin
                ctrl.load_regfile = 1'b1;
                ctrl.aluop        = arith_op(funct3, funct7[5], opcode == op_reg);
                if (opcode == op_reg)
                    alumux2_sel = mux2_rs2;
                else
                    cmpmux_sel = cmp_i_imm;
                if (funct3 == 3'b010)
                    ctrl.cmpop = 3'b100; // blt
                else if (funct3 == 3'b011)
                    ctrl.cmpop = 3'b110; // bltu
            end
            default: ;
        endcase

        // Opcode and funct3 only mean something for known instructions
        if (opcode inside {op_lui, op_auipc, op_jal, op_jalr, op_br,
                           op_load, op_store, op_imm, op_reg})
        begin
            ctrl.opcode = opcode;
            ctrl.funct3 = funct3;
        end
        if (ctrl.load_regfile)
            ctrl.rd = data[11:7];
    end

endmodule

// File: design/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  rv32i_pkg::rv32i_word         instr,
    input  rv32i_pkg::rv32i_control_word id_ex,
    output logic                         bubble
);
    import rv32i_pkg::*;

    logic [4:0]  rs1;
    logic [4:0]  rs2;
    rv32i_opcode op;
    logic        uses_rs2;
    logic        load_in_ex;

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign op  = rv32i_opcode'(instr[6:0]);

    // R, S and B formats read rs2
    assign uses_rs2 = (op == op_reg) || (op == op_store) || (op == op_br);

    assign load_in_ex = id_ex.mem_read && (id_ex.rd != 5'd0);

    assign bubble = load_in_ex &&
                    ((id_ex.rd == rs1) || (uses_rs2 && (id_ex.rd == rs2)));

endmodule

// File: design/branch_predictor.sv
`timescale 1ns/1ps
`include "rv32i_defs.svh"

module branch_predictor #(
    parameter int PRED_IDX_W = 4
) (
    input logic     clk,
    input logic     rst,
    bp_if.predictor bp
);
    import rv32i_pkg::*;

    localparam int ENTRIES = 2 ** PRED_IDX_W;

    logic [1:0]            ctr [ENTRIES];
    logic [PRED_IDX_W-1:0] idx;

    assign idx    = bp.pc[PRED_IDX_W+1:2]; // word aligned PC
    assign bp.idx = idx;

    // Lookup
    assign bp.pred      = (bp.op == op_br) && ctr[idx][1];
    assign bp.pred_addr = bp.pc + bp.imm;

    // Saturating update from execute
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < ENTRIES; i++)
                ctr[i] <= `CTR_RESET;
        end
        else if (bp.update)
        begin
            if (bp.taken)
            begin
                if (ctr[bp.update_idx] != 2'b11)
                    ctr[bp.update_idx] <= ctr[bp.update_idx] + 2'd1;
            end
            else if (ctr[bp.update_idx] != 2'b00)
            begin
                ctr[bp.update_idx] <= ctr[bp.update_idx] - 2'd1;
            end
        end
    end

endmodule

// File: design/instruction_decode.sv
`timescale 1ns/1ps

module instruction_decode #(
    parameter int PRED_IDX_W = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  rv32i_pkg::rv32i_word         pc,
    input  rv32i_pkg::rv32i_word         instr,      // From I cache
    input  logic                         if_stall,
    input  logic                         ma_stall,
    input  rv32i_pkg::rv32i_word         rd_in,      // WB write port
    input  logic [4:0]                   rd,
    input  logic                         load_regfile,
    input  logic                         br_miss,
    input  logic                         pred_update,
    input  logic                         pred_taken,
    output rv32i_pkg::rv32i_control_word ctrl_out,
    output rv32i_pkg::rv32i_word         instruction_out,
    output rv32i_pkg::rv32i_word         pc_out,
    output rv32i_pkg::rv32i_word         alu_in_1_out,
    output rv32i_pkg::rv32i_word         alu_in_2_out,
    output rv32i_pkg::rv32i_word         cmp_in_out,
    output rv32i_pkg::rv32i_word         rs1_out,
    output rv32i_pkg::rv32i_word         rs2_out,
    output logic                         bubble,
    output logic                         pred,       // Back to IF
    output rv32i_pkg::rv32i_word         pred_addr,
    output logic                         pred_ff,    // On to EX
    bp_if.decode                         bp
);
    import rv32i_pkg::*;

    rv32i_word i_imm, s_imm, b_imm, u_imm, j_imm;

    rv32i_control_word ctrl;
    alumux1_sel_t      alumux1_sel;
    alumux2_sel_t      alumux2_sel;
    cmpmux_sel_t       cmpmux_sel;
    rv32i_word         alu_in_1, alu_in_2, cmp_in;
    rv32i_word         reg_a, reg_b;

    logic [PRED_IDX_W-1:0] pred_idx_ff;

    assign i_imm = {{20{instr[31]}}, instr[31:20]};
    assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign b_imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'h000};
    assign j_imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    regfile regfile_inst (
        .clk   (clk),
        .rst   (rst),
        .load  (load_regfile),
        .in    (rd_in),
        .src_a (instr[19:15]),
        .src_b (instr[24:20]),
        .dest  (rd),
        .reg_a (reg_a),
        .reg_b (reg_b)
    );

    hazard_unit hazard_unit_inst (
        .instr  (instr),
        .id_ex  (ctrl_out),
        .bubble (bubble)
    );

    control_rom control_rom_inst (
        .data        (instr),
        .ctrl        (ctrl),
        .alumux1_sel (alumux1_sel),
        .alumux2_sel (alumux2_sel),
        .cmpmux_sel  (cmpmux_sel)
    );

    // Predictor side
    assign bp.pc         = pc;
    assign bp.op         = rv32i_opcode'(instr[6:0]);
    assign bp.imm        = b_imm;
    assign bp.update     = pred_update;
    assign bp.taken      = pred_taken;
    assign bp.update_idx = pred_idx_ff; // index travels with the branch
    assign pred          = bp.pred;
    assign pred_addr     = bp.pred_addr;

    always_comb
    begin
        unique case (alumux1_sel)
            mux1_pc: alu_in_1 = pc;
            default: alu_in_1 = reg_a;
        endcase

        unique case (alumux2_sel)
            mux2_i_imm: alu_in_2 = i_imm;
            mux2_u_imm: alu_in_2 = u_imm;
            mux2_b_imm: alu_in_2 = b_imm;
            mux2_s_imm: alu_in_2 = s_imm;
            mux2_j_imm: alu_in_2 = j_imm;
            default:    alu_in_2 = reg_b;
        endcase

        unique case (cmpmux_sel)
            cmp_i_imm: cmp_in = i_imm;
            default:   cmp_in = reg_b;
        endcase
    end

    // ID/EX register where a stall wins over a flush
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc_out          <= '0;
            instruction_out <= '0;
            ctrl_out        <= '0;
            alu_in_1_out    <= '0;
            alu_in_2_out    <= '0;
            cmp_in_out      <= '0;
            rs1_out         <= '0;
            rs2_out         <= '0;
            pred_ff         <= 1'b0;
        end
        else if (!ma_stall && (br_miss || bubble))
        begin
            pc_out          <= '0;
            instruction_out <= NOP_INSTR;
            ctrl_out        <= '0;
            alu_in_1_out    <= '0;
            alu_in_2_out    <= '0;
            cmp_in_out      <= '0;
            rs1_out         <= '0;
            rs2_out         <= '0;
            pred_ff         <= 1'b0;
        end
        else if (!ma_stall)
        begin
            pc_out          <= pc;
            instruction_out <= instr;
            ctrl_out        <= ctrl;
            alu_in_1_out    <= alu_in_1;
            alu_in_2_out    <= alu_in_2;
            cmp_in_out      <= cmp_in;
            rs1_out         <= reg_a;
            rs2_out         <= reg_b;
            pred_ff         <= if_stall ? 1'b0 : pred;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!ma_stall)
            pred_idx_ff <= bp.idx;
    end

endmodule

// File: design/id_stage_top.sv
`timescale 1ns/1ps

module id_stage_top #(
    parameter int PRED_IDX_W = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  rv32i_pkg::rv32i_word         pc,
    input  rv32i_pkg::rv32i_word         instr,
    input  logic                         if_stall,
    input  logic                         ma_stall,
    input  rv32i_pkg::rv32i_word         rd_in,
    input  logic [4:0]                   rd,
    input  logic                         load_regfile,
    input  logic                         br_miss,
    input  logic                         pred_update,
    input  logic                         pred_taken,
    output rv32i_pkg::rv32i_control_word ctrl_out,
    output rv32i_pkg::rv32i_word         instruction_out,
    output rv32i_pkg::rv32i_word         pc_out,
    output rv32i_pkg::rv32i_word         alu_in_1_out,
    output rv32i_pkg::rv32i_word         alu_in_2_out,
    output rv32i_pkg::rv32i_word         cmp_in_out,
    output rv32i_pkg::rv32i_word         rs1_out,
    output rv32i_pkg::rv32i_word         rs2_out,
    output logic                         bubble,
    output logic                         pred,
    output rv32i_pkg::rv32i_word         pred_addr,
    output logic                         pred_ff
);

    bp_if #(.PRED_IDX_W(PRED_IDX_W)) bp_inst ();

    instruction_decode #(.PRED_IDX_W(PRED_IDX_W)) instruction_decode_inst (
        .clk             (clk),
        .rst             (rst),
        .pc              (pc),
        .instr           (instr),
        .if_stall        (if_stall),
        .ma_stall        (ma_stall),
        .rd_in           (rd_in),
        .rd              (rd),
        .load_regfile    (load_regfile),
        .br_miss         (br_miss),
        .pred_update     (pred_update),
        .pred_taken      (pred_taken),
        .ctrl_out        (ctrl_out),
        .instruction_out (instruction_out),
        .pc_out          (pc_out),
        .alu_in_1_out    (alu_in_1_out),
        .alu_in_2_out    (alu_in_2_out),
        .cmp_in_out      (cmp_in_out),
        .rs1_out         (rs1_out),
        .rs2_out         (rs2_out),
        .bubble          (bubble),
        .pred            (pred),
        .pred_addr       (pred_addr),
        .pred_ff         (pred_ff),
        .bp              (bp_inst.decode)
    );

    branch_predictor #(.PRED_IDX_W(PRED_IDX_W)) branch_predictor_inst (
        .clk (clk),
        .rst (rst),
        .bp  (bp_inst.predictor)
    );

endmodule

// File: bench/id_stage_checker.sv
`timescale 1ns/1ps

module id_stage_checker #(
    parameter int PRED_IDX_W = 4
) (
    input logic                         clk,
    input logic                         rst,
    input rv32i_pkg::rv32i_word         pc,
    input rv32i_pkg::rv32i_word         instr,
    input logic                         if_stall,
    input logic                         ma_stall,
    input rv32i_pkg::rv32i_word         rd_in,
    input logic [4:0]                   rd,
    input logic                         load_regfile,
    input logic                         br_miss,
    input logic                         pred_update,
    input logic                         pred_taken,
    input rv32i_pkg::rv32i_control_word ctrl_out,
    input rv32i_pkg::rv32i_word         instruction_out,
    input rv32i_pkg::rv32i_word         pc_out,
    input rv32i_pkg::rv32i_word         alu_in_1_out,
    input rv32i_pkg::rv32i_word         alu_in_2_out,
    input rv32i_pkg::rv32i_word         cmp_in_out,
    input rv32i_pkg::rv32i_word         rs1_out,
    input rv32i_pkg::rv32i_word         rs2_out,
    input logic                         bubble,
    input logic                         pred,
    input rv32i_pkg::rv32i_word         pred_addr,
    input logic                         pred_ff
);
    import rv32i_pkg::*;

    localparam int OUT_W = $bits(rv32i_control_word) + 7 * 32 + 1;

    int unsigned fail_count;

    // Reference model state
    rv32i_word             shadow [32];
    logic [1:0]            ctr [2**PRED_IDX_W];
    logic [4:0]            ld_rd;               // rd of a load sitting in EX
    logic [PRED_IDX_W-1:0] upd_idx;
    logic                  stalled;
    logic                  loaded;
    logic                  flushed;

    // What the last edge should have captured
    rv32i_opcode      op_q;
    rv32i_word        instr_q, pc_q, rs1_q, rs2_q, alu1_q, alu2_q;
    logic             pred_ff_q;
    logic [OUT_W-1:0] outs, outs_q;

    rv32i_opcode           op;
    logic [4:0]            rs1, rs2;
    rv32i_word             exp_rs1, exp_rs2, exp_alu1, exp_alu2, b_imm;
    logic                  exp_bubble, exp_pred, flush;
    logic [PRED_IDX_W-1:0] idx;

    assign outs = {ctrl_out, instruction_out, pc_out, alu_in_1_out, alu_in_2_out,
                   cmp_in_out, rs1_out, rs2_out, pred_ff};

    always_comb
    begin
        op  = rv32i_opcode'(instr[6:0]);
        rs1 = instr[19:15];
        rs2 = instr[24:20];

        // x0 is zero, a write in the same cycle shows at once
        if (rs1 == 5'd0)
            exp_rs1 = '0;
        else if (load_regfile && rd == rs1)
            exp_rs1 = rd_in;
        else
            exp_rs1 = shadow[rs1];
        if (rs2 == 5'd0)
            exp_rs2 = '0;
        else if (load_regfile && rd == rs2)
            exp_rs2 = rd_in;
        else
            exp_rs2 = shadow[rs2];

        b_imm    = 32'($signed({instr[31], instr[7], instr[30:25], instr[11:8], 1'b0}));
        exp_alu1 = (op == op_jal) ? pc : exp_rs1;
        case (op)
            op_lui:  exp_alu2 = {instr[31:12], 12'h000};
            op_jal:
                exp_alu2 = 32'($signed({instr[31], instr[19:12], instr[20],
                                        instr[30:21], 1'b0}));
            default: exp_alu2 = 32'($signed(instr[31:20]));
        endcase

        exp_bubble = (ld_rd != 5'd0) &&
                     (ld_rd == rs1 || (op inside {op_reg, op_store, op_br} && ld_rd == rs2));
        flush      = br_miss || exp_bubble;
        idx        = pc[PRED_IDX_W+1:2];
        exp_pred   = (op == op_br) && ctr[idx][1];
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 32; i++)
                shadow[i] <= '0;
            for (int i = 0; i < 2**PRED_IDX_W; i++)
                ctr[i] <= 2'b01; // weakly not taken
            ld_rd   <= '0;
            stalled <= 1'b0;
            loaded  <= 1'b0;
            flushed <= 1'b0;
        end
        else
        begin
            if (load_regfile && rd != 5'd0)
                shadow[rd] <= rd_in;
            if (pred_update && pred_taken && ctr[upd_idx] < 2'd3)
                ctr[upd_idx] <= ctr[upd_idx] + 2'd1;
            else if (pred_update && !pred_taken && ctr[upd_idx] > 2'd0)
                ctr[upd_idx] <= ctr[upd_idx] - 2'd1;
            stalled <= ma_stall;
            loaded  <= !ma_stall && !flush;
            flushed <= !ma_stall && flush;
            if (!ma_stall)
                ld_rd <= (!flush && op == op_load) ? instr[11:7] : 5'd0;
        end
    end

    always_ff @(posedge clk)
    begin
        outs_q <= outs;
        if (!ma_stall)
        begin
            op_q      <= op;
            instr_q   <= instr;
            pc_q      <= pc;
            rs1_q     <= exp_rs1;
            rs2_q     <= exp_rs2;
            alu1_q    <= exp_alu1;
            alu2_q    <= exp_alu2;
            pred_ff_q <= exp_pred && !if_stall;
            upd_idx   <= idx; // travels with the branch
        end
    end

    a_bubble: assert property (@(posedge clk) disable iff (rst) bubble == exp_bubble)
    else
    begin
        $error("[FAIL] bubble got %h expected %h", $sampled(bubble), $sampled(exp_bubble));
        fail_count++;
    end

    a_stall_hold: assert property (@(posedge clk) disable iff (rst) stalled |-> outs == outs_q)
    else
    begin
        $error("[FAIL] ID/EX outputs got %h expected %h", $sampled(outs), $sampled(outs_q));
        fail_count++;
    end

    a_flush: assert property (@(posedge clk) disable iff (rst)
        flushed |-> instruction_out == NOP_INSTR && ctrl_out == '0 && rs1_out == '0 && !pred_ff)
    else
    begin
        $error("[FAIL] instruction_out got %h expected %h, ctrl_out got %h expected 0",
               $sampled(instruction_out), NOP_INSTR, $sampled(ctrl_out));
        fail_count++;
    end

    a_pass: assert property (@(posedge clk) disable iff (rst)
        loaded |-> instruction_out == instr_q && pc_out == pc_q)
    else
    begin
        $error("[FAIL] instruction_out got %h expected %h, pc_out got %h expected %h",
               $sampled(instruction_out), $sampled(instr_q), $sampled(pc_out), $sampled(pc_q));
        fail_count++;
    end

    a_regs: assert property (@(posedge clk) disable iff (rst)
        loaded |-> rs1_out == rs1_q && rs2_out == rs2_q)
    else
    begin
        $error("[FAIL] rs1_out got %h expected %h, rs2_out got %h expected %h",
               $sampled(rs1_out), $sampled(rs1_q), $sampled(rs2_out), $sampled(rs2_q));
        fail_count++;
    end

    a_alu1: assert property (@(posedge clk) disable iff (rst)
        loaded && op_q inside {op_imm, op_jal} |-> alu_in_1_out == alu1_q)
    else
    begin
        $error("[FAIL] alu_in_1_out got %h expected %h", $sampled(alu_in_1_out),
               $sampled(alu1_q));
        fail_count++;
    end

    a_alu2: assert property (@(posedge clk) disable iff (rst)
        loaded && op_q inside {op_imm, op_lui, op_jal} |-> alu_in_2_out == alu2_q)
    else
    begin
        $error("[FAIL] alu_in_2_out got %h expected %h", $sampled(alu_in_2_out),
               $sampled(alu2_q));
        fail_count++;
    end

    a_cmp: assert property (@(posedge clk) disable iff (rst)
        loaded && op_q == op_br |-> cmp_in_out == rs2_q)
    else
    begin
        $error("[FAIL] cmp_in_out got %h expected %h", $sampled(cmp_in_out), $sampled(rs2_q));
        fail_count++;
    end

    a_pred: assert property (@(posedge clk) disable iff (rst) pred == exp_pred)
    else
    begin
        $error("[FAIL] pred got %h expected %h", $sampled(pred), $sampled(exp_pred));
        fail_count++;
    end

    a_pred_addr: assert property (@(posedge clk) disable iff (rst)
        op == op_br |-> pred_addr == pc + b_imm)
    else
    begin
        $error("[FAIL] pred_addr got %h expected %h", $sampled(pred_addr),
               $sampled(pc + b_imm));
        fail_count++;
    end

    a_pred_ff: assert property (@(posedge clk) disable iff (rst) loaded |-> pred_ff == pred_ff_q)
    else
    begin
        $error("[FAIL] pred_ff got %h expected %h", $sampled(pred_ff), $sampled(pred_ff_q));
        fail_count++;
    end

endmodule

// File: bench/id_stage_tb.sv
`timescale 1ns/1ps

module id_stage_tb;
    import rv32i_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int PRED_IDX_W   = 4;
    localparam int RESET_CYCLES = 4;

    // Length of each directed sequence
    localparam int REG_CYCLES     = 4;
    localparam int OPERAND_CYCLES = 4;
    localparam int HAZARD_CYCLES  = 3;
    localparam int FLUSH_CYCLES   = 5;
    localparam int PRED_CYCLES    = 7;
    localparam int DRAIN_CYCLES   = 2;
    localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + REG_CYCLES + OPERAND_CYCLES +
                                          HAZARD_CYCLES + FLUSH_CYCLES + PRED_CYCLES +
                                          DRAIN_CYCLES) + 20;

    localparam rv32i_word ADD_X6_X5_X0  = 32'h00028333;
    localparam rv32i_word ADD_X10_X0_X5 = 32'h00500533;
    localparam rv32i_word ADD_X9_X8_X5  = 32'h005404B3;
    localparam rv32i_word ADDI_X11_X5   = 32'hFFB28593; // addi x11, x5, -5
    localparam rv32i_word LUI_X12       = 32'hABCDE637;
    localparam rv32i_word JAL_X1        = 32'hFFDFF0EF; // jal x1, -4
    localparam rv32i_word BEQ_X5_X6     = 32'hFE6288E3; // beq x5, x6, -16
    localparam rv32i_word LW_X7         = 32'h0002A383; // lw x7, 0(x5)
    localparam rv32i_word ADD_X13_X7_X0 = 32'h000386B3;

    logic              clk;
    logic              rst;
    rv32i_word         pc;
    rv32i_word         instr;
    logic              if_stall;
    logic              ma_stall;
    rv32i_word         rd_in;
    logic [4:0]        rd;
    logic              load_regfile;
    logic              br_miss;
    logic              pred_update;
    logic              pred_taken;
    rv32i_control_word ctrl_out;
    rv32i_word         instruction_out;
    rv32i_word         pc_out;
    rv32i_word         alu_in_1_out;
    rv32i_word         alu_in_2_out;
    rv32i_word         cmp_in_out;
    rv32i_word         rs1_out;
    rv32i_word         rs2_out;
    logic              bubble;
    logic              pred;
    rv32i_word         pred_addr;
    logic              pred_ff;

    logic [31:0] lfsr_state;

    id_stage_top #(.PRED_IDX_W(PRED_IDX_W)) id_stage_top_inst (.*);

    bind id_stage_top id_stage_checker #(.PRED_IDX_W(PRED_IDX_W)) checker_inst (.*);

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic random_word(output rv32i_word w);
        w = '0;
        for (int i = 0; i < 32; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[30:0], lfsr_state[0]}; // one step per bit
        end
    endtask

    // New fetch on the falling edge with the strobes back to idle
    task automatic present(input rv32i_word p, input rv32i_word i);
        @(negedge clk);
        pc           = p;
        instr        = i;
        load_regfile = 1'b0;
        br_miss      = 1'b0;
        ma_stall     = 1'b0;
        if_stall     = 1'b0;
        pred_update  = 1'b0;
        pred_taken   = 1'b0;
    endtask

    task automatic write_reg(input logic [4:0] dest);
        rv32i_word w;
        random_word(w);
        load_regfile = 1'b1;
        rd           = dest;
        rd_in        = w;
    endtask

    task automatic taken_update(input logic taken);
        pred_update = 1'b1;
        pred_taken  = taken;
    endtask

    initial
    begin
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $fatal(1, "Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    end

    initial
    begin
        wait (id_stage_top_inst.checker_inst.fail_count != 0);
        $display("TEST FAILED");
        $fatal(1, "Decode checker reported an assertion failure");
    end

    initial
    begin
        lfsr_state   = 32'h1539;
        rst          = 1'b1;
        pc           = '0;
        instr        = NOP_INSTR;
        if_stall     = 1'b0;
        ma_stall     = 1'b0;
        rd_in        = '0;
        rd           = 5'd0;
        load_regfile = 1'b0;
        br_miss      = 1'b0;
        pred_update  = 1'b0;
        pred_taken   = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        // Register file
        present(32'h100, NOP_INSTR);
        write_reg(5'd5);
        present(32'h104, ADD_X6_X5_X0);
        present(32'h108, ADD_X10_X0_X5);
        write_reg(5'd0); // x0 drops the write
        present(32'h10C, ADD_X9_X8_X5);
        write_reg(5'd8); // read sees it through write-through

        // Operand muxes
        present(32'h110, ADDI_X11_X5);
        write_reg(5'd6);
        present(32'h114, LUI_X12);
        present(32'h118, JAL_X1);
        present(32'h11C, BEQ_X5_X6);

        // Load-use
        present(32'h120, LW_X7);
        present(32'h124, ADD_X13_X7_X0);
        present(32'h124, ADD_X13_X7_X0); // reissue after the bubble

        // Flush, then stall with and without a flush request
        present(32'h128, ADDI_X11_X5);
        br_miss = 1'b1;
        present(32'h12C, LUI_X12);
        present(32'h130, JAL_X1);
        ma_stall = 1'b1;
        present(32'h134, ADDI_X11_X5);
        ma_stall = 1'b1;
        br_miss  = 1'b1;
        present(32'h134, ADDI_X11_X5);

        // Predictor at index 1
        present(32'h144, BEQ_X5_X6);
        present(32'h144, BEQ_X5_X6);
        taken_update(1'b1);
        present(32'h144, BEQ_X5_X6);
        taken_update(1'b1);
        present(32'h144, BEQ_X5_X6);
        if_stall = 1'b1;
        present(32'h144, BEQ_X5_X6);
        present(32'h144, BEQ_X5_X6);
        taken_update(1'b0);
        present(32'h148, NOP_INSTR);

        repeat (DRAIN_CYCLES) @(negedge clk);
        if (id_stage_top_inst.checker_inst.fail_count != 0)
        begin
            $display("TEST FAILED");
            $fatal(1, "Decode checker counted %0d failures",
                   id_stage_top_inst.checker_inst.fail_count);
        end
        else
        begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

// File: list.f
+incdir+include
design/rv32i_pkg.sv
design/bp_if.sv
design/regfile.sv
design/control_rom.sv
design/hazard_unit.sv
design/branch_predictor.sv
design/instruction_decode.sv
design/id_stage_top.sv
bench/id_stage_checker.sv
bench/id_stage_tb.sv

// File: Bender.yml
package:
  name: rv32i_id_stage

export_include_dirs:
  - include

sources:
  - files:
      - design/rv32i_pkg.sv
      - design/bp_if.sv
      - design/regfile.sv
      - design/control_rom.sv
      - design/hazard_unit.sv
      - design/branch_predictor.sv
      - design/instruction_decode.sv
      - design/id_stage_top.sv
  - target: test
    files:
      - bench/id_stage_checker.sv
      - bench/id_stage_tb.sv
